/* filelist.f */
+incdir+.
scope_pkg.sv
cmd_receiver.sv
cmd_controller.sv
stream_sender.sv
capture_buffer.sv
trigger_unit.sv
scope_top.sv
tb_scope.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scope
RTL_TOP   ?= scope_top
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= filelist.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD) -o sim

run: build
	./$(BUILD)/sim | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_scope_tasks.svh */
// stream tasks and reference helpers of the testbench, included inside tb_scope
// every wait loop gives up after TIMEOUT cycles and counts an error

`ifndef TB_SCOPE_TASKS_SVH
`define TB_SCOPE_TASKS_SVH

function automatic scope_pkg::frame_t frame_of(input scope_pkg::byte_t op,
		input scope_pkg::byte_t b1, input scope_pkg::byte_t b2,
		input scope_pkg::byte_t b3, input scope_pkg::word_t hi);
	return {hi, b3, b2, b1, op}; // bytes 4..7 little endian
endfunction

function automatic scope_pkg::sample_t invert_sat(input scope_pkg::sample_t x);
	if (x == 12'h800)
		return 12'h7ff; // -2048 clips
	return -x;
endfunction

function automatic scope_pkg::word_t pack_half(input scope_pkg::sample_t lo,
		input scope_pkg::sample_t hi);
	return {4'b0, hi, 4'b0, lo};
endfunction

task automatic set_lanes(input scope_pkg::sample_t l0, input scope_pkg::sample_t l1,
		input scope_pkg::sample_t l2, input scope_pkg::sample_t l3);
	@(posedge clk);
	samples <= {l3, l2, l1, l0};
endtask

task automatic send_frame(input scope_pkg::frame_t f);
	int n;
	@(posedge clk);
	for (int i = 0; i < 8; i++) begin
		rx_tvalid <= 1'b1;
		rx_tdata  <= f[8*i +: 8];
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rx_tready && n < TIMEOUT);
		if (!rx_tready) begin
			$display("timeout: command byte %0d was never accepted", i);
			errors++;
		end
		@(posedge clk); // byte taken here
	end
	rx_tvalid <= 1'b0;
endtask

// collects beats until tlast, bp randomizes tready
task automatic recv_beats(input bit bp);
	int               idle;
	bit               done;
	bit               stalled;
	scope_pkg::word_t held;
	idle    = 0;
	done    = 0;
	stalled = 0;
	held    = '0;
	rx_words.delete();
	rx_keeps.delete();
	rx_lasts.delete();
	while (!done && idle < TIMEOUT) begin
		@(posedge clk);
		tx_tready <= bp ? 1'($urandom % 2) : 1'b1;
		@(negedge clk);
		if (tx_tvalid && stalled)
			assert (tx_tdata == held) else begin
				$display("error at %0t: data changed while stalled", $time);
				errors++;
			end
		stalled = 0;
		if (tx_tvalid && tx_tready) begin
			rx_words.push_back(tx_tdata);
			rx_keeps.push_back(tx_tkeep);
			rx_lasts.push_back(tx_tlast);
			done = tx_tlast;
			idle = 0;
		end else begin
			if (tx_tvalid) begin
				stalled = 1;
				held    = tx_tdata;
			end
			idle++;
		end
	end
	if (!done) begin
		$display("timeout: reply stream never ended with tlast");
		errors++;
	end
	@(posedge clk);
	tx_tready <= 1'b1;
endtask

task automatic check_single(input scope_pkg::word_t exp);
	recv_beats(1'b0);
	assert (rx_words.size() == 1) else begin
		$display("error at %0t: reply had %0d beats", $time, rx_words.size());
		errors++;
	end
	if (rx_words.size() == 1)
		assert (rx_words[0] == exp && rx_keeps[0] == 4'hf && rx_lasts[0]) else begin
			$display("error at %0t: reply %h keep %b, expected %h", $time, rx_words[0],
			         rx_keeps[0], exp);
			errors++;
		end
endtask

task automatic expect_silence(input int cycles);
	for (int i = 0; i < cycles; i++) begin
		@(negedge clk);
		assert (!tx_tvalid) else begin
			$display("error at %0t: reply to a dropped command", $time);
			errors++;
		end
	end
endtask

task automatic poll_ready(input bit ttype, input scope_pkg::take_len_t take);
	int n;
	bit ok;
	ok = 0;
	n  = 0;
	while (!ok && n < POLLS) begin // arm repeats, only acts in IDLE
		send_frame(frame_of(scope_pkg::OP_ARM, {7'd0, ttype}, 8'd0, 8'd0, {16'd0, take}));
		recv_beats(1'b0);
		if (rx_words.size() == 1 && rx_words[0] == 32'd251)
			ok = 1;
		n++;
	end
	if (!ok) begin
		$display("timeout: acquisition never reached the ready state");
		errors++;
	end
endtask

task automatic read_event(input scope_pkg::word_t len, input bit bp);
	send_frame(frame_of(scope_pkg::OP_READOUT, 8'd0, 8'd0, 8'd0, len));
	recv_beats(bp);
endtask

task automatic report(input string name, input int e0);
	tests_run++;
	if (errors == e0) begin
		$display("test %s: ok", name);
	end else begin
		tests_failed++;
		$display("test %s: failed", name);
	end
endtask

`endif

/* tb_scope.sv */
// testbench for the acquisition core, single clock, 40 ns period
// replies are read at the falling edge, inputs change on the rising edge
// test 6 compares a back-pressured readout with a free-running one of the same data

`timescale 1ns/1ps

module tb_scope;

	localparam int TIMEOUT = 200; // cycles per wait loop
	localparam int POLLS   = 60;  // arm polls before giving up
	localparam int N_CMD   = 5;

	logic                  clk;
	logic                  rstn;
	logic                  rx_tvalid;
	scope_pkg::byte_t      rx_tdata;
	logic                  rx_tready;
	logic                  tx_tready;
	logic                  tx_tvalid;
	scope_pkg::word_t      tx_tdata;
	logic [3:0]            tx_tkeep;
	logic                  tx_tlast;
	scope_pkg::row_t       samples;

	int                    errors;
	int                    tests_run;
	int                    tests_failed;
	scope_pkg::word_t      rx_words[$]; // beats of the last reply
	logic [3:0]            rx_keeps[$];
	logic                  rx_lasts[$];

	// command table, expected single word reply or none
	scope_pkg::frame_t     cmd_tab[N_CMD];
	scope_pkg::word_t      exp_tab[N_CMD];
	bit                    reply_tab[N_CMD];

	scope_top i_dut (
		.clk(clk), .rstn(rstn), .i_rx_tvalid(rx_tvalid), .i_rx_tdata(rx_tdata),
		.o_rx_tready(rx_tready), .i_tx_tready(tx_tready), .o_tx_tvalid(tx_tvalid),
		.o_tx_tdata(tx_tdata), .o_tx_tkeep(tx_tkeep), .o_tx_tlast(tx_tlast),
		.i_samples(samples));

	always #20 clk = ~clk;

	`include "tb_scope_tasks.svh"

	initial begin
		int                 e0;
		scope_pkg::sample_t raw_lo, raw_hi;
		scope_pkg::word_t   ref_words[$];
		scope_pkg::word_t   w_lo, w_hi, w0, w1;

		void'($urandom(63)); // one seed for the whole run
		clk          = 1'b0;
		rstn         = 1'b0;
		rx_tvalid    = 1'b0;
		rx_tdata     = '0;
		tx_tready    = 1'b1;
		samples      = {4{12'h800}}; // -2048 on every lane
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		cmd_tab[0] = frame_of(scope_pkg::OP_INFO, 8'd0, 8'd0, 8'd0, 32'd0);
		exp_tab[0] = 32'(scope_pkg::FW_VERSION);
		reply_tab[0] = 1'b1;
		cmd_tab[1] = frame_of(scope_pkg::OP_INFO, 8'd3, 8'd0, 8'd0, 32'd0);
		exp_tab[1] = 32'd0;                  // no event yet
		reply_tab[1] = 1'b1;
		cmd_tab[2] = frame_of(scope_pkg::OP_TRIG_SET, 8'd128, 8'd10, 8'd16, 32'h0000_0300);
		exp_tab[2] = 32'd8;                  // pre 16, tot 3
		reply_tab[2] = 1'b1;
		cmd_tab[3] = frame_of(8'd5, 8'd0, 8'd0, 8'd0, 32'd0);
		exp_tab[3] = 32'd0;
		reply_tab[3] = 1'b0;                 // unknown opcode
		cmd_tab[4] = frame_of(scope_pkg::OP_INFO, 8'd0, 8'd0, 8'd0, 32'd0);
		exp_tab[4] = 32'(scope_pkg::FW_VERSION);
		reply_tab[4] = 1'b1;

		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		repeat (300) @(posedge clk); // fill the ring with the constant input

		// --------------------------------------------------
		// tests 1 and 2, command table
		// --------------------------------------------------
		for (int t = 0; t < N_CMD; t++) begin
			e0 = errors;
			send_frame(cmd_tab[t]);
			if (reply_tab[t])
				check_single(exp_tab[t]);
			else
				expect_silence(40);
			report($sformatf("command %0d", t), e0);
		end

		// test 3, immediate trigger on a saturated input
		e0 = errors;
		send_frame(frame_of(scope_pkg::OP_ARM, 8'd0, 8'd0, 8'd0, 32'd20));
		check_single(32'd0);                  // was IDLE
		poll_ready(1'b0, 16'd20);
		read_event(32'd160, 1'b0);
		assert (rx_words.size() == 40) else begin
			$display("error at %0t: readout gave %0d beats, expected 40", $time, rx_words.size());
			errors++;
		end
		for (int i = 0; i < rx_words.size(); i++)
			assert (rx_words[i] == 32'h07ff_07ff && rx_keeps[i] == 4'hf
			        && rx_lasts[i] == (i == 39)) else begin
				$display("error at %0t: beat %0d is %h keep %b last %b", $time, i,
				         rx_words[i], rx_keeps[i], rx_lasts[i]);
				errors++;
			end
		send_frame(frame_of(scope_pkg::OP_INFO, 8'd3, 8'd0, 8'd0, 32'd0));
		check_single(32'd1);                  // one event captured
		report("immediate trigger", e0);

		// test 4, partial last beat
		e0 = errors;
		read_event(32'd10, 1'b0);
		assert (rx_words.size() == 3) else begin
			$display("error at %0t: 10 byte readout gave %0d beats", $time, rx_words.size());
			errors++;
		end
		if (rx_words.size() == 3)
			assert (rx_keeps[0] == 4'hf && rx_keeps[1] == 4'hf && rx_keeps[2] == 4'h3
			        && !rx_lasts[0] && !rx_lasts[1] && rx_lasts[2]) else begin
				$display("error at %0t: wrong tkeep or tlast on a 10 byte readout", $time);
				errors++;
			end
		report("short readout", e0);

		// test 5, rising trigger, tot 3, pre-offset 16
		e0 = errors;
		raw_lo = 12'sd1000;                   // conditioned -1000, below lower
		raw_hi = -12'sd1000;                  // conditioned +1000, above upper
		set_lanes(raw_lo, raw_lo, raw_lo, raw_lo);
		send_frame(frame_of(scope_pkg::OP_ARM, 8'd1, 8'd0, 8'd0, 32'd64));
		check_single(32'd0);
		repeat (5) @(posedge clk);
		set_lanes(raw_hi, raw_hi, raw_hi, raw_hi);
		@(posedge clk);
		set_lanes(raw_lo, raw_lo, raw_lo, raw_lo); // two cycles high only
		repeat (5) @(posedge clk);
		send_frame(frame_of(scope_pkg::OP_ARM, 8'd1, 8'd0, 8'd0, 32'd64));
		recv_beats(1'b0);
		assert (rx_words.size() == 1 && rx_words[0] inside {32'd1, 32'd2}) else begin
			$display("error at %0t: short pulse moved the acquisition on", $time);
			errors++;
		end
		repeat (40) @(posedge clk);
		set_lanes(raw_hi, raw_hi, raw_hi, raw_hi);
		repeat (100) @(posedge clk);
		poll_ready(1'b1, 16'd64);
		read_event(32'd640, 1'b0);            // 16 pre rows + 64 post rows
		w_lo = pack_half(invert_sat(raw_lo), invert_sat(raw_lo));
		w_hi = pack_half(invert_sat(raw_hi), invert_sat(raw_hi));
		assert (rx_words.size() == 160) else begin
			$display("error at %0t: readout gave %0d beats, expected 160", $time, rx_words.size());
			errors++;
		end
		if (rx_words.size() == 160)
			assert (rx_words[0] == w_lo && rx_words[1] == w_lo
			        && rx_words[158] == w_hi && rx_words[159] == w_hi) else begin
				$display("error at %0t: first row %h, last row %h", $time, rx_words[0],
				         rx_words[159]);
				errors++;
			end
		report("rising trigger", e0);

		// test 6, same readout with and without back-pressure
		e0 = errors;
		set_lanes(12'sd100, -12'sd200, 12'sd300, -12'sd400);
		repeat (300) @(posedge clk);
		w0 = pack_half(invert_sat(12'sd100), invert_sat(-12'sd200));
		w1 = pack_half(invert_sat(12'sd300), invert_sat(-12'sd400));
		send_frame(frame_of(scope_pkg::OP_ARM, 8'd0, 8'd0, 8'd0, 32'd16));
		check_single(32'd0);
		poll_ready(1'b0, 16'd16);
		read_event(32'd128, 1'b0);
		ref_words = rx_words;
		for (int i = 0; i < ref_words.size(); i++)
			assert (ref_words[i] == ((i % 2) ? w1 : w0)) else begin
				$display("error at %0t: beat %0d is %h", $time, i, ref_words[i]);
				errors++;
			end
		send_frame(frame_of(scope_pkg::OP_ARM, 8'd0, 8'd0, 8'd0, 32'd16));
		check_single(32'd0);
		poll_ready(1'b0, 16'd16);
		read_event(32'd128, 1'b1);
		assert (rx_words.size() == 32 && ref_words.size() == 32) else begin
			$display("error at %0t: readouts gave %0d and %0d beats, expected 32", $time,
			         ref_words.size(), rx_words.size());
			errors++;
		end
		if (rx_words.size() == ref_words.size())
			for (int i = 0; i < rx_words.size(); i++)
				assert (rx_words[i] == ref_words[i]) else begin
					$display("error at %0t: back-pressured beat %0d is %h, expected %h",
					         $time, i, rx_words[i], ref_words[i]);
					errors++;
				end
		report("back-pressure", e0);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* scope_top.sv */
// acquisition core top: byte command stream in, 32-bit answer stream out
// one clock for everything, the adc row is taken every cycle on i_samples

`timescale 1ns/1ps

module scope_top (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_rx_tvalid,
	input  scope_pkg::byte_t   i_rx_tdata,
	output logic               o_rx_tready,
	input  logic               i_tx_tready,
	output logic               o_tx_tvalid,
	output scope_pkg::word_t   o_tx_tdata,
	output logic [3:0]         o_tx_tkeep,
	output logic               o_tx_tlast,
	input  scope_pkg::row_t    i_samples
);

	// --------------------------------------------------
	// command path
	// --------------------------------------------------
	scope_pkg::frame_t     frame;
	logic                  frame_valid, frame_done;
	logic                  start, beat_taken, busy;
	scope_pkg::word_t      len_bytes, word;
	scope_pkg::buf_addr_t  rd_addr, trig_addr;
	scope_pkg::row_t       rd_row, cond_samples;
	// --------------------------------------------------
	// acquisition path
	// --------------------------------------------------
	logic                  arm, trig_type, read_done, wr_en, trig_latch;
	scope_pkg::take_len_t  take_len;
	scope_pkg::sample_t    lower, upper;
	scope_pkg::tot_t       tot;
	scope_pkg::acq_state_e acq_state;
	scope_pkg::word_t      event_count;

	cmd_receiver i_rx (
		.clk(clk), .rstn(rstn), .i_rx_tvalid(i_rx_tvalid), .i_rx_tdata(i_rx_tdata),
		.o_rx_tready(o_rx_tready), .i_frame_done(frame_done), .o_frame(frame),
		.o_frame_valid(frame_valid));

	cmd_controller i_ctl (
		.clk(clk), .rstn(rstn), .i_frame(frame), .i_frame_valid(frame_valid),
		.o_frame_done(frame_done), .o_start(start), .o_len_bytes(len_bytes), .o_word(word),
		.i_beat_taken(beat_taken), .i_busy(busy), .o_rd_addr(rd_addr), .i_rd_row(rd_row),
		.i_trig_addr(trig_addr), .o_arm(arm), .o_trig_type(trig_type), .o_take_len(take_len),
		.o_lower(lower), .o_upper(upper), .o_tot(tot), .o_read_done(read_done),
		.i_acq_state(acq_state), .i_event_count(event_count));

	stream_sender i_tx (
		.clk(clk), .rstn(rstn), .i_start(start), .i_len_bytes(len_bytes), .i_word(word),
		.o_beat_taken(beat_taken), .o_busy(busy), .i_tx_tready(i_tx_tready),
		.o_tx_tvalid(o_tx_tvalid), .o_tx_tdata(o_tx_tdata), .o_tx_tkeep(o_tx_tkeep),
		.o_tx_tlast(o_tx_tlast));

	capture_buffer i_buf (
		.clk(clk), .rstn(rstn), .i_samples(i_samples), .i_wr_en(wr_en),
		.i_trig_latch(trig_latch), .o_cond_samples(cond_samples), .o_trig_addr(trig_addr),
		.i_rd_addr(rd_addr), .o_rd_row(rd_row));

	trigger_unit i_trig (
		.clk(clk), .rstn(rstn), .i_cond_samples(cond_samples), .i_arm(arm),
		.i_trig_type(trig_type), .i_take_len(take_len), .i_lower(lower), .i_upper(upper),
		.i_tot(tot), .i_read_done(read_done), .o_wr_en(wr_en), .o_trig_latch(trig_latch),
		.o_acq_state(acq_state), .o_event_count(event_count));

endmodule

/* trigger_unit.sv */
// acquisition FSM: immediate or rising threshold trigger with time over threshold
// any of the four lanes can fire, thresholds are signed adc counts
// in READY nothing is written until the event has been read out

`timescale 1ns/1ps

module trigger_unit (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::row_t        i_cond_samples,
	input  logic                   i_arm,
	input  logic                   i_trig_type,
	input  scope_pkg::take_len_t   i_take_len,
	input  scope_pkg::sample_t     i_lower,
	input  scope_pkg::sample_t     i_upper,
	input  scope_pkg::tot_t        i_tot,
	input  logic                   i_read_done,
	output logic                   o_wr_en,
	output logic                   o_trig_latch,
	output scope_pkg::acq_state_e  o_acq_state,
	output scope_pkg::word_t       o_event_count
);

	scope_pkg::tot_t       tot_cnt;  // consecutive cycles above upper
	scope_pkg::take_len_t  post_cnt; // rows taken after the trigger
	scope_pkg::sample_t    lane;
	logic                  any_below, any_above;

	assign o_wr_en = (o_acq_state != scope_pkg::READY); // keep history while waiting

	always_comb begin
		any_below = 1'b0;
		any_above = 1'b0;
		lane      = '0;
		for (int k = 0; k < scope_pkg::N_LANES; k++) begin
			lane = i_cond_samples[k*scope_pkg::SAMPLE_W +: scope_pkg::SAMPLE_W];
			if (lane < i_lower)
				any_below = 1'b1;
			if (lane > i_upper)
				any_above = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_acq_state   <= scope_pkg::IDLE;
			o_trig_latch  <= 1'b0;
			o_event_count <= '0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
		end else begin
			o_trig_latch <= 1'b0; // pulse
			case (o_acq_state)
				scope_pkg::IDLE: begin
					tot_cnt  <= '0;
					post_cnt <= 16'd1;
					if (i_arm && !i_trig_type) begin // immediate
						o_trig_latch <= 1'b1;
						o_acq_state  <= scope_pkg::POST;
					end else if (i_arm) begin
						o_acq_state <= scope_pkg::WAIT_LOW;
					end
				end
				scope_pkg::WAIT_LOW: if (any_below) o_acq_state <= scope_pkg::WAIT_HIGH;
				scope_pkg::WAIT_HIGH: begin
					if (!any_above) begin // pulse too short, start over
						tot_cnt     <= '0;
						o_acq_state <= scope_pkg::WAIT_LOW;
					end else if (tot_cnt + 8'd1 >= i_tot) begin
						o_trig_latch <= 1'b1;
						o_acq_state  <= scope_pkg::POST;
					end else begin
						tot_cnt <= tot_cnt + 8'd1;
					end
				end
				scope_pkg::POST: begin
					if (post_cnt >= i_take_len) begin
						o_event_count <= o_event_count + 32'd1;
						o_acq_state   <= scope_pkg::READY;
					end else begin
						post_cnt <= post_cnt + 16'd1;
					end
				end
				scope_pkg::READY: if (i_read_done) o_acq_state <= scope_pkg::IDLE;
				default: o_acq_state <= scope_pkg::IDLE;
			endcase
		end
	end

endmodule

/* capture_buffer.sv */
// input conditioning and the 256 row ring buffer
// samples are inverted, -2048 has no positive twin and becomes +2047
// the write pointer advances on every write and wraps around the ring

`timescale 1ns/1ps

module capture_buffer (
	input  logic                  clk,
	input  logic                  rstn,
	input  scope_pkg::row_t       i_samples,
	input  logic                  i_wr_en,
	input  logic                  i_trig_latch,
	output scope_pkg::row_t       o_cond_samples,
	output scope_pkg::buf_addr_t  o_trig_addr,
	input  scope_pkg::buf_addr_t  i_rd_addr,
	output scope_pkg::row_t       o_rd_row
);

	scope_pkg::row_t      mem [2**scope_pkg::BUF_ADDR_W];
	scope_pkg::buf_addr_t wr_ptr;
	scope_pkg::row_t      cond_next;
	scope_pkg::sample_t   raw;

	// --------------------------------------------------
	// saturating inversion, per lane
	// --------------------------------------------------
	always_comb begin
		cond_next = '0;
		raw       = '0;
		for (int k = 0; k < scope_pkg::N_LANES; k++) begin
			raw = i_samples[k*scope_pkg::SAMPLE_W +: scope_pkg::SAMPLE_W];
			if (raw == {1'b1, {(scope_pkg::SAMPLE_W-1){1'b0}}}) // most negative code
				cond_next[k*scope_pkg::SAMPLE_W +: scope_pkg::SAMPLE_W] =
					{1'b0, {(scope_pkg::SAMPLE_W-1){1'b1}}};
			else
				cond_next[k*scope_pkg::SAMPLE_W +: scope_pkg::SAMPLE_W] = -raw;
		end
	end

	// --------------------------------------------------
	// ram and pointers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		o_cond_samples <= cond_next; // also what the trigger looks at
		if (i_wr_en)
			mem[wr_ptr] <= o_cond_samples;
		o_rd_row <= mem[i_rd_addr]; // one cycle read
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			o_trig_addr <= '0;
		end else begin
			if (i_wr_en)
				wr_ptr <= wr_ptr + 8'd1;
			if (i_trig_latch)
				o_trig_addr <= wr_ptr; // row being written at the trigger
		end
	end

endmodule

/* stream_sender.sv */
// 32-bit stream master, sends i_len_bytes bytes as ceil(len/4) beats
// valid drops for one cycle after each accepted beat and the next
// word is taken from i_word when valid rises again

`timescale 1ns/1ps

module stream_sender (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_start,
	input  scope_pkg::word_t   i_len_bytes,
	input  scope_pkg::word_t   i_word,
	output logic               o_beat_taken,
	output logic               o_busy,
	input  logic               i_tx_tready,
	output logic               o_tx_tvalid,
	output scope_pkg::word_t   o_tx_tdata,
	output logic [3:0]         o_tx_tkeep,
	output logic               o_tx_tlast
);

	scope_pkg::word_t remaining; // bytes left including the current beat
	logic             busy_q;
	logic             rearm;     // raise valid again next cycle

	assign o_beat_taken = o_tx_tvalid && i_tx_tready;
	assign o_busy       = busy_q || i_start; // busy from the start pulse on
	assign o_tx_tlast   = (remaining <= 32'd4);
	assign o_tx_tkeep   = (remaining >= 32'd4) ? 4'b1111 :
	                      (remaining == 32'd3) ? 4'b0111 :
	                      (remaining == 32'd2) ? 4'b0011 :
	                      (remaining == 32'd1) ? 4'b0001 : 4'b0000;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			remaining   <= '0;
			busy_q      <= 1'b0;
			rearm       <= 1'b0;
			o_tx_tvalid <= 1'b0;
		end else begin
			rearm <= 1'b0;
			if (i_start) begin
				remaining   <= i_len_bytes;
				busy_q      <= 1'b1;
				o_tx_tvalid <= 1'b1;
			end else if (o_beat_taken) begin
				o_tx_tvalid <= 1'b0;
				if (o_tx_tlast) begin // done
					remaining <= '0;
					busy_q    <= 1'b0;
				end else begin
					remaining <= remaining - 32'd4;
					rearm     <= 1'b1;
				end
			end else if (rearm) begin
				o_tx_tvalid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_start || rearm)
			o_tx_tdata <= i_word; // held while valid is up
	end

endmodule

/* cmd_controller.sv */
// decodes one frame at a time: readout, arm, info and trigger settings
// unknown opcodes are dropped silently, the receiver is freed right away
// readout fetches one ram row per two beats, the read address runs one row ahead

`timescale 1ns/1ps

module cmd_controller (
	input  logic                      clk,
	input  logic                      rstn,
	input  scope_pkg::frame_t         i_frame,
	input  logic                      i_frame_valid,
	output logic                      o_frame_done,
	output logic                      o_start,
	output scope_pkg::word_t          o_len_bytes,
	output scope_pkg::word_t          o_word,
	input  logic                      i_beat_taken,
	input  logic                      i_busy,
	output scope_pkg::buf_addr_t      o_rd_addr,
	input  scope_pkg::row_t           i_rd_row,
	input  scope_pkg::buf_addr_t      i_trig_addr,
	output logic                      o_arm,
	output logic                      o_trig_type,
	output scope_pkg::take_len_t      o_take_len,
	output scope_pkg::sample_t        o_lower,
	output scope_pkg::sample_t        o_upper,
	output scope_pkg::tot_t           o_tot,
	output logic                      o_read_done,
	input  scope_pkg::acq_state_e     i_acq_state,
	input  scope_pkg::word_t          i_event_count
);

	scope_pkg::ctl_state_e    state;
	scope_pkg::byte_t         op, b1, b2, b3, b5;
	scope_pkg::buf_addr_t     pre_offset;  // rows shown before the trigger
	scope_pkg::word_t         reply_word;
	logic                     half;        // 0 lanes 1:0, 1 lanes 3:2
	logic                     launch;      // readout start waits one cycle for the ram
	logic [23:0]              row_half;
	logic [11:0]              thr_base_lo, thr_base_hi;

	assign op = i_frame[7:0];
	assign b1 = i_frame[15:8];
	assign b2 = i_frame[23:16];
	assign b3 = i_frame[31:24];
	assign b5 = i_frame[47:40];

	// thresholds in adc counts, ((b1 -+ b2 - 128) * 16) + 8 mod 4096
	assign thr_base_lo = {4'b0, b1} - {4'b0, b2} - 12'd128;
	assign thr_base_hi = {4'b0, b1} + {4'b0, b2} - 12'd128;

	assign row_half = half ? i_rd_row[47:24] : i_rd_row[23:0];
	assign o_word   = (state == scope_pkg::READ) ? {4'b0, row_half[23:12], 4'b0, row_half[11:0]}
	                                             : reply_word;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state        <= scope_pkg::RECV;
			o_frame_done <= 1'b0;
			o_start      <= 1'b0;
			o_arm        <= 1'b0;
			o_read_done  <= 1'b0;
			launch       <= 1'b0;
			half         <= 1'b0;
			o_rd_addr    <= '0;
			o_trig_type  <= 1'b0;
			o_take_len   <= '0;
			o_lower      <= '0;
			o_upper      <= '0;
			o_tot        <= '0;
			pre_offset   <= '0;
		end else begin
			o_frame_done <= 1'b0; // pulses
			o_start      <= 1'b0;
			o_arm        <= 1'b0;
			o_read_done  <= 1'b0;
			case (state)
				scope_pkg::RECV: if (i_frame_valid) state <= scope_pkg::DECODE;
				scope_pkg::DECODE: begin
					o_len_bytes <= 32'd4; // single word replies
					state       <= scope_pkg::REPLY;
					o_start     <= 1'b1;
					case (op)
						scope_pkg::OP_READOUT: begin
							o_len_bytes <= i_frame[63:32];
							o_rd_addr   <= i_trig_addr - pre_offset; // wraps in the ring
							half        <= 1'b0;
							launch      <= 1'b1;
							o_start     <= 1'b0;
							state       <= scope_pkg::READ;
						end
						scope_pkg::OP_ARM: begin
							o_trig_type <= b1[0];             // 0 immediate, 1 rising
							o_take_len  <= i_frame[47:32];
							o_arm       <= 1'b1;              // only acts in IDLE
							reply_word  <= {24'd0, i_acq_state}; // state before the arm
						end
						scope_pkg::OP_INFO: begin
							if (b1 == 8'd0)
								reply_word <= 32'(scope_pkg::FW_VERSION);
							else if (b1 == 8'd3)
								reply_word <= i_event_count;
							else
								reply_word <= 32'd0;
						end
						scope_pkg::OP_TRIG_SET: begin
							o_lower    <= {thr_base_lo[7:0], 4'b0} + 12'd8;
							o_upper    <= {thr_base_hi[7:0], 4'b0} + 12'd8;
							pre_offset <= b3;
							o_tot      <= b5;
							reply_word <= 32'd8;
						end
						default: begin // unknown, no reply
							o_start      <= 1'b0;
							o_frame_done <= 1'b1;
							state        <= scope_pkg::RECV;
						end
					endcase
				end
				scope_pkg::REPLY: begin
					if (!i_busy) begin
						o_frame_done <= 1'b1;
						state        <= scope_pkg::RECV;
					end
				end
				scope_pkg::READ: begin
					if (launch) begin // first row is on i_rd_row now
						launch  <= 1'b0;
						o_start <= 1'b1;
					end else if (!i_busy) begin
						o_read_done  <= 1'b1; // event counts as read
						o_frame_done <= 1'b1;
						state        <= scope_pkg::RECV;
					end else if (i_beat_taken) begin
						half <= !half;
						if (!half)
							o_rd_addr <= o_rd_addr + 8'd1; // prefetch, high half still held
					end
				end
				default: state <= scope_pkg::RECV;
			endcase
		end
	end

endmodule

/* cmd_receiver.sv */
// collects eight stream bytes into one command frame, byte 0 first
// after the eighth byte the slave stalls until the controller frees it

`timescale 1ns/1ps

module cmd_receiver (
	input  logic                clk,
	input  logic                rstn,
	input  logic                i_rx_tvalid,
	input  scope_pkg::byte_t    i_rx_tdata,
	output logic                o_rx_tready,
	input  logic                i_frame_done,
	output scope_pkg::frame_t   o_frame,
	output logic                o_frame_valid
);

	logic [2:0] byte_cnt; // next byte slot
	logic       blocked;  // frame handed over, waiting for done

	assign o_rx_tready = !blocked;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= 3'd0;
			blocked       <= 1'b0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0; // one cycle pulse
			if (i_frame_done)
				blocked <= 1'b0;
			if (i_rx_tvalid && o_rx_tready) begin
				byte_cnt <= byte_cnt + 3'd1; // wraps back to 0 after byte 7
				if (byte_cnt == 3'd7) begin
					o_frame_valid <= 1'b1;
					blocked       <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_rx_tvalid && o_rx_tready)
			o_frame[{byte_cnt, 3'b000} +: 8] <= i_rx_tdata; // little endian slots
	end

endmodule

/* scope_pkg.sv */
// shared widths, types, opcodes and state codes of the acquisition core
// everything runs on one clock, the ring buffer holds 256 rows of 4 lanes
// acq_state_e codes go to the host as plain numbers, keep them fixed

package scope_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int N_LANES    = 4;  // adc lanes per clock
	localparam int SAMPLE_W   = 12; // bits per sample
	localparam int BUF_ADDR_W = 8;  // 256 rows
	localparam int FW_VERSION = 19; // returned by info, byte 1 = 0

	typedef logic signed [SAMPLE_W-1:0]      sample_t;
	typedef logic [N_LANES*SAMPLE_W-1:0]     row_t;      // lane 0 in the low bits
	typedef logic [BUF_ADDR_W-1:0]           buf_addr_t;
	typedef logic [7:0]                      byte_t;
	typedef logic [31:0]                     word_t;
	typedef logic [63:0]                     frame_t;    // byte 0 in the low bits
	typedef logic [7:0]                      tot_t;
	typedef logic [15:0]                     take_len_t;

	// --------------------------------------------------
	// command opcodes, byte 0 of a frame
	// --------------------------------------------------
	localparam byte_t OP_READOUT  = 8'd0;
	localparam byte_t OP_ARM      = 8'd1;
	localparam byte_t OP_INFO     = 8'd2;
	localparam byte_t OP_TRIG_SET = 8'd8;

	typedef enum logic [7:0] {
		IDLE      = 8'd0,   // writing, waiting for arm
		WAIT_LOW  = 8'd1,   // rising trigger, first wait for a low sample
		WAIT_HIGH = 8'd2,   // then count cycles above upper
		POST      = 8'd250, // triggered, taking the post-trigger rows
		READY     = 8'd251  // frozen until read out
	} acq_state_e;

	typedef enum logic [1:0] {RECV, DECODE, REPLY, READ} ctl_state_e;

endpackage
